// File: Bender.yml
package:
  name: strm_read_port

sources:
  - include_dirs:
      - .
    files:
      - mpmc_pkg.sv
      - strm_req_stage.sv
      - strm_read_cache.sv
      - strm_fill_ctrl.sv
      - strm_resp_stage.sv
      - strm_read_port.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clkgen.sv
      - tb_strm_read_port.sv

// File: mpmc_defs.svh
`ifndef MPMC_DEFS_SVH
`define MPMC_DEFS_SVH

// ======================================================================
// Stream cache geometry
// ======================================================================

`define MPMC_LINE_BITS      128                         // One cache line
`define MPMC_LINE_WORDS     (`MPMC_LINE_BITS / 32)      // 32-bit words per line
`define MPMC_LINE_LSB       4                           // Byte offset bits inside a line
`define MPMC_LINE_IDX_BITS  7                           // 128 lines in the block RAM
`define MPMC_SEG_BITS       3                           // 8 segments
`define MPMC_TAG_LSB        11                          // Tag is address bits 31 to 11

// Line-in-segment offset width, 4 bits for 16 lines per segment
`define MPMC_LOFS_BITS      (`MPMC_LINE_IDX_BITS - `MPMC_SEG_BITS)
`define MPMC_SEG_LSB        (`MPMC_LINE_LSB + `MPMC_LOFS_BITS)  // Segment index starts at bit 8
`define MPMC_SEG_LINES      (1 << `MPMC_LOFS_BITS)      // Lines fetched per miss
`define MPMC_LINES          (1 << `MPMC_LINE_IDX_BITS)  // Depth of the line RAM
`define MPMC_SEGS           (1 << `MPMC_SEG_BITS)       // Number of tag entries
`define MPMC_TAG_BITS       (32 - `MPMC_TAG_LSB)        // Stored tag width

`endif

// File: mpmc_pkg.sv
`include "mpmc_defs.svh"

package mpmc_pkg;

  // ====================================================================
  // Payloads passed between the read port stages
  // ====================================================================

  // A cache line, word 0 sits at the low end
  typedef logic [`MPMC_LINE_WORDS-1:0][31:0] strm_line_t;

  // Read request as it leaves the request stage
  typedef struct packed {
    logic        valid;   // Request present this cycle
    logic        replay;  // Set only on the request re-issued after a fill
    logic [31:0] adr;     // Byte address
  } strm_req_t;

  // Result of one cache lookup
  typedef struct packed {
    logic        valid;   // A lookup completed this cycle
    logic        hit;     // Tag matched and the segment is valid
    logic        replay;  // Lookup belongs to a replayed request
    logic [31:0] adr;     // Address of the request
    strm_line_t  line;    // Line read from the RAM
  } strm_look_t;

  // Line write from the fill controller into the cache
  typedef struct packed {
    logic        wr;      // Write strobe
    logic [31:0] adr;     // Line address, offset bits are zero
    strm_line_t  line;    // Line data returned by memory
  } strm_fill_t;

  // Response to the requester
  typedef struct packed {
    logic        valid;   // One-cycle response pulse
    logic        hit;     // Word was served without a fill
    logic [31:0] dat;     // Addressed word
  } strm_rsp_t;

  // States of the miss handler
  typedef enum logic [1:0] {
    st_idle,
    st_req,
    st_wait,
    st_replay
  } fill_state_t;

endpackage

// File: src.f
+incdir+.
mpmc_pkg.sv
strm_req_stage.sv
strm_read_cache.sv
strm_fill_ctrl.sv
strm_resp_stage.sv
strm_read_port.sv
tb_clkgen.sv
tb_strm_read_port.sv

// File: strm_fill_ctrl.sv
`timescale 1ns/1ns
`include "mpmc_defs.svh"

module strm_fill_ctrl
  import mpmc_pkg::*;
(
  input  logic        rst,
  input  logic        rclk,
  input  strm_look_t  look,
  input  logic        mem_ack,
  input  strm_line_t  mem_dat,
  output logic        mem_req,
  output logic [31:0] mem_adr,
  output strm_fill_t  fill,
  output strm_req_t   replay,
  output logic        stall
);

  localparam logic [`MPMC_LOFS_BITS-1:0] last_line = `MPMC_SEG_LINES - 1;

  fill_state_t                state;
  logic [`MPMC_LOFS_BITS-1:0] cnt;        // Line of the segment being fetched
  logic [31:0]                miss_adr;   // Address of the read that missed
  logic                       miss;       // Completed lookup did not hit
  logic                       last;       // Counter is on the final line

  // Registered cache write, one cycle behind mem_ack
  logic                       fill_wr;
  logic [31:0]                fill_adr;
  strm_line_t                 fill_line;

  assign miss = look.valid & ~look.hit;
  assign last = (cnt == last_line);

  // ======================================================================
  // Segment walk
  // ======================================================================

  always_ff @(posedge rclk) begin
    if (rst) begin
      state <= st_idle;
      cnt   <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (miss) begin
            state <= st_req;
            cnt   <= '0;       // Fetch starts at line 0 of the segment
          end
        end
        st_req: begin
          state <= st_wait;    // Request pulse lasts one cycle
        end
        st_wait: begin
          if (mem_ack && !last) begin
            state <= st_req;
            cnt   <= cnt + 1'b1;
          end else if (fill_wr && last) begin
            // Final line is in the RAM now, so the replay reads fresh data
            state <= st_replay;
          end
        end
        st_replay: begin
          state <= st_idle;
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  always_ff @(posedge rclk) begin
    if (state == st_idle && miss) begin
      miss_adr <= look.adr;   // Kept for the line addresses and the replay
    end
  end

  // ======================================================================
  // Memory side and cache write
  // ======================================================================

  assign mem_req = (state == st_req);
  assign mem_adr = {miss_adr[31:`MPMC_SEG_LSB], cnt, {`MPMC_LINE_LSB{1'b0}}};

  always_ff @(posedge rclk) begin
    if (rst) begin
      fill_wr <= 1'b0;
    end else begin
      fill_wr <= (state == st_wait) & mem_ack;
    end
  end

  always_ff @(posedge rclk) begin
    if (state == st_wait && mem_ack) begin
      fill_adr  <= mem_adr;    // mem_adr is still stable while waiting
      fill_line <= mem_dat;
    end
  end

  always_comb begin
    fill.wr   = fill_wr;
    fill.adr  = fill_adr;
    fill.line = fill_line;
  end

  // ======================================================================
  // Replay and stall
  // ======================================================================

  always_comb begin
    replay.valid  = (state == st_replay);
    replay.replay = 1'b1;     // Marks the lookup as served after a fill
    replay.adr    = miss_adr;
  end

  // Miss cycle raises stall directly, the replay cycle already lets go
  assign stall = (state == st_idle & miss) | (state == st_req) | (state == st_wait);

endmodule

// File: strm_read_cache.sv
`timescale 1ns/1ns
`include "mpmc_defs.svh"

module strm_read_cache
  import mpmc_pkg::*;
(
  input  logic        rst,
  input  logic        rclk,
  input  strm_req_t   req,
  input  strm_fill_t  fill,
  input  logic        inv,
  input  logic [31:0] inv_adr,
  output strm_look_t  look
);

  // ======================================================================
  // Storage
  // ======================================================================

  strm_line_t                ram  [0:`MPMC_LINES-1];  // Block RAM of lines
  logic [`MPMC_TAG_BITS-1:0] tags [0:`MPMC_SEGS-1];   // One tag per segment
  logic [`MPMC_SEGS-1:0]     vbit;                    // One valid bit per segment

  logic [`MPMC_SEG_BITS-1:0] wr_seg;    // Segment hit by a fill write
  logic [`MPMC_SEG_BITS-1:0] inv_seg;   // Segment named by an invalidate
  logic [`MPMC_SEG_BITS-1:0] rd_seg;    // Segment of the request being read

  // Read side registers, all loaded at the same edge as the RAM output
  logic                      rd_vld;
  logic                      rd_replay;
  logic [31:0]               rd_adr_q;
  strm_line_t                rd_line;
  logic [`MPMC_TAG_BITS-1:0] tag_q;
  logic                      vld_q;

  assign wr_seg  = fill.adr[`MPMC_TAG_LSB-1:`MPMC_SEG_LSB];
  assign inv_seg = inv_adr[`MPMC_TAG_LSB-1:`MPMC_SEG_LSB];
  assign rd_seg  = req.adr[`MPMC_TAG_LSB-1:`MPMC_SEG_LSB];

  always_ff @(posedge rclk) begin
    if (fill.wr) begin
      ram[fill.adr[`MPMC_TAG_LSB-1:`MPMC_LINE_LSB]] <= fill.line;
    end
    rd_line <= ram[req.adr[`MPMC_TAG_LSB-1:`MPMC_LINE_LSB]];  // Registered read
  end

  always_ff @(posedge rclk) begin
    if (fill.wr) begin
      tags[wr_seg] <= fill.adr[31:`MPMC_TAG_LSB];  // Each line write restates the tag
    end
  end

  // Write wins over an invalidate in the same cycle
  always_ff @(posedge rclk) begin
    if (rst) begin
      vbit <= '0;
    end else if (fill.wr) begin
      vbit[wr_seg] <= 1'b1;
    end else if (inv) begin
      vbit[inv_seg] <= 1'b0;
    end
  end

  // ======================================================================
  // Lookup pipeline
  // ======================================================================

  always_ff @(posedge rclk) begin
    if (rst) begin
      rd_vld <= 1'b0;
    end else begin
      rd_vld <= req.valid;
    end
  end

  always_ff @(posedge rclk) begin
    rd_adr_q  <= req.adr;       // Address travels with the RAM read
    rd_replay <= req.replay;
    tag_q     <= tags[rd_seg];  // Tag and valid sampled beside the line
    vld_q     <= vbit[rd_seg];
  end

  always_comb begin
    look.valid  = rd_vld;
    look.hit    = rd_vld & vld_q & (tag_q == rd_adr_q[31:`MPMC_TAG_LSB]);
    look.replay = rd_replay;
    look.adr    = rd_adr_q;
    look.line   = rd_line;
  end

endmodule

// File: strm_read_port.sv
`timescale 1ns/1ns
`include "mpmc_defs.svh"

module strm_read_port
  import mpmc_pkg::*;
(
  input  logic        rst,
  input  logic        rclk,
  input  logic        rd_req,
  input  logic [31:0] rd_adr,
  output logic        rd_busy,
  input  logic        inv,
  input  logic [31:0] inv_adr,
  output strm_rsp_t   rsp,
  output logic        mem_req,
  output logic [31:0] mem_adr,
  input  logic        mem_ack,
  input  strm_line_t  mem_dat
);

  strm_req_t  req;      // Request stage to cache
  strm_req_t  replay;   // Fill controller back into the request stage
  strm_look_t look;     // Cache lookup to fill controller and response stage
  strm_fill_t fill;     // Fill controller to cache write port
  logic       stall;
  logic       inv_ok;   // Invalidate outside a fill

  assign rd_busy = stall;         // Requester holds off while a miss is open
  assign inv_ok  = inv & ~stall;  // A segment being filled is not invalidated

  // ======================================================================
  // Pipeline
  // ======================================================================

  strm_req_stage u_req_stage (
    .rst, .rclk, .rd_req, .rd_adr, .stall, .replay, .req
  );

  strm_read_cache u_read_cache (
    .rst, .rclk, .req, .fill, .inv(inv_ok), .inv_adr, .look
  );

  strm_fill_ctrl u_fill_ctrl (
    .rst, .rclk, .look, .mem_ack, .mem_dat, .mem_req, .mem_adr,
    .fill, .replay, .stall
  );

  strm_resp_stage u_resp_stage (
    .rst, .rclk, .look, .rsp
  );

endmodule

// File: strm_req_stage.sv
`timescale 1ns/1ns
`include "mpmc_defs.svh"

module strm_req_stage
  import mpmc_pkg::*;
(
  input  logic        rst,
  input  logic        rclk,
  input  logic        rd_req,
  input  logic [31:0] rd_adr,
  input  logic        stall,
  input  strm_req_t   replay,
  output strm_req_t   req
);

  logic        held_vld;   // Request register holds a live request
  logic [31:0] held_adr;   // Its byte address
  logic        hold;       // Keep the held request where it is
  logic        load;       // Capture the incoming strobe and address

  // A replay also holds the register, the frozen request goes out after it
  assign hold = stall | replay.valid;

  // An empty register may still take a request while the port is stalled
  assign load = ~hold | ~held_vld;

  always_ff @(posedge rclk) begin
    if (rst) begin
      held_vld <= 1'b0;
    end else if (load) begin
      held_vld <= rd_req;
    end
  end

  always_ff @(posedge rclk) begin
    if (load) begin
      held_adr <= rd_adr;  // Address payload follows the strobe
    end
  end

  // ======================================================================
  // Output select
  // ======================================================================

  always_comb begin
    if (replay.valid) begin
      req = replay;                     // Replay goes ahead of anything held
    end else begin
      req.valid  = held_vld & ~stall;   // Frozen request is not looked up
      req.replay = 1'b0;                // Fresh requests never carry the marker
      req.adr    = held_adr;
    end
  end

endmodule

// File: strm_resp_stage.sv
`timescale 1ns/1ns
`include "mpmc_defs.svh"

module strm_resp_stage
  import mpmc_pkg::*;
(
  input  logic       rst,
  input  logic       rclk,
  input  strm_look_t look,
  output strm_rsp_t  rsp
);

  logic [`MPMC_LINE_LSB-3:0] wsel;     // Word of the line, address bits 3 to 2
  logic                      take;     // Lookup produces a response
  logic                      rsp_vld;
  logic                      rsp_hit;
  logic [31:0]               rsp_dat;

  assign wsel = look.adr[`MPMC_LINE_LSB-1:2];

  // A missing lookup is owned by the fill controller and is dropped here
  assign take = look.valid & look.hit;

  always_ff @(posedge rclk) begin
    if (rst) begin
      rsp_vld <= 1'b0;
    end else begin
      rsp_vld <= take;   // One pulse per served read
    end
  end

  always_ff @(posedge rclk) begin
    if (take) begin
      rsp_dat <= look.line[wsel];
      rsp_hit <= ~look.replay;   // Replayed reads report that a fill happened
    end
  end

  always_comb begin
    rsp.valid = rsp_vld;
    rsp.hit   = rsp_hit;
    rsp.dat   = rsp_dat;
  end

endmodule

// File: tb_clkgen.sv
`timescale 1ns/1ns

module tb_clkgen (
  output logic rclk,
  output logic rst
);

  initial begin
    rclk = 1'b0;
    forever #50 rclk = ~rclk;  // 100 ns period
  end

  // Synchronous reset held over the first three rising edges
  initial begin
    rst = 1'b1;
    repeat (3) @(posedge rclk);
    rst <= 1'b0;
  end

endmodule

// File: tb_strm_read_port.sv
`timescale 1ns/1ns
`include "mpmc_defs.svh"

module tb_strm_read_port
  import mpmc_pkg::*;
();

  // One row of the stimulus table
  typedef struct packed {
    logic        is_inv;  // Invalidate instead of a read
    logic [31:0] adr;     // Byte address
    logic [2:0]  gap;     // Idle cycles before the row is applied
    logic        hit;     // Expected lookup result of a read
  } step_t;

  // Expected responses in request order
  typedef struct packed {
    logic [31:0] dat;
    logic        hit;
    logic        chk_lat;  // A hit with nothing ahead of it has the fixed latency
    logic [31:0] edge_no;  // Rising edge that drove the request
  } expect_t;

  localparam int n_steps   = 26;
  localparam int wd_cycles = n_steps * (`MPMC_SEG_LINES * 6 + 10);

  logic        rclk, rst;
  logic        rd_req, rd_busy, inv, mem_req, mem_ack;
  logic [31:0] rd_adr, inv_adr, mem_adr;
  strm_rsp_t   rsp;
  strm_line_t  mem_dat;

  step_t                     steps [0:n_steps-1];
  expect_t                   exp_q [$];
  logic [31:0]               fill_q [$];     // Segment bases to be fetched in miss order
  logic [`MPMC_TAG_BITS-1:0] ref_tag [0:`MPMC_SEGS-1];
  logic [`MPMC_SEGS-1:0]     ref_vld;
  logic [31:0]               edge_no;
  logic [31:0]               lcg_state;
  int                        mem_cnt;        // Line of the current segment fetch

  tb_clkgen u_clkgen (.rclk, .rst);

  strm_read_port u_strm_read_port (
    .rst, .rclk, .rd_req, .rd_adr, .rd_busy, .inv, .inv_adr, .rsp,
    .mem_req, .mem_adr, .mem_ack, .mem_dat
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Memory content is a fixed function of the word address
  function automatic logic [31:0] mem_word(input logic [31:0] adr);
    return {2'b00, adr[31:2]} ^ 32'h3c5a_e196;
  endfunction

  function automatic strm_line_t mem_line(input logic [31:0] line_adr);
    strm_line_t l;
    for (int w = 0; w < `MPMC_LINE_WORDS; w++) begin
      l[w] = mem_word(line_adr + 32'(4 * w));
    end
    return l;
  endfunction

  function automatic step_t make_step(input logic is_inv, input logic [31:0] adr,
                                      input logic [2:0] gap, input logic hit);
    step_t s;
    s.is_inv = is_inv;
    s.adr    = adr;
    s.gap    = gap;
    s.hit    = hit;
    return s;
  endfunction

  task automatic abort_run();
    $display("Finished with errors");
    $fatal(1);
  endtask

  // Reference cache with one tag and one valid bit per segment
  task automatic predict_read(input logic [31:0] adr, output logic hit);
    logic [`MPMC_SEG_BITS-1:0] seg;
    seg = adr[`MPMC_TAG_LSB-1:`MPMC_SEG_LSB];
    hit = ref_vld[seg] && (ref_tag[seg] == adr[31:`MPMC_TAG_LSB]);
    if (!hit) begin
      ref_tag[seg] = adr[31:`MPMC_TAG_LSB];  // Whole segment comes in on a miss
      ref_vld[seg] = 1'b1;
      fill_q.push_back({adr[31:`MPMC_SEG_LSB], {`MPMC_SEG_LSB{1'b0}}});
    end
  endtask

  initial edge_no = '0;
  always @(posedge rclk) edge_no <= edge_no + 1'b1;

  // ====================================================================
  // Stimulus table and driver
  // ====================================================================

  initial begin : driver
    step_t   st;
    expect_t ex;
    logic    hit;
    logic    prev_miss;   // Last read issued is expected to miss
    logic    drain_due;   // Follower of a miss went in so the pipe must empty
    logic    need_drain;
    steps[0]  = make_step(1'b0, 32'h0009_1a34, 3'd0, 1'b0);  // First touch of segment 2
    steps[1]  = make_step(1'b0, 32'h0009_1a00, 3'd0, 1'b1);  // Frozen behind the miss
    steps[2]  = make_step(1'b0, 32'h0009_1af4, 3'd0, 1'b1);
    steps[3]  = make_step(1'b0, 32'h0009_1a58, 3'd0, 1'b1);  // Back to back hits
    steps[4]  = make_step(1'b0, 32'h0009_1a6c, 3'd0, 1'b1);
    steps[5]  = make_step(1'b0, 32'h0009_1a84, 3'd2, 1'b1);
    steps[6]  = make_step(1'b0, 32'h0009_1d10, 3'd1, 1'b0);  // Segment 5
    steps[7]  = make_step(1'b0, 32'h0009_1a40, 3'd0, 1'b1);
    steps[8]  = make_step(1'b0, 32'h0009_1d1c, 3'd0, 1'b1);
    steps[9]  = make_step(1'b0, 32'h0009_1d20, 3'd0, 1'b1);
    steps[10] = make_step(1'b0, 32'h0009_1a48, 3'd0, 1'b1);
    steps[11] = make_step(1'b0, 32'h0052_e2c8, 3'd3, 1'b0);  // New tag in segment 2
    steps[12] = make_step(1'b0, 32'h0052_e204, 3'd2, 1'b1);
    steps[13] = make_step(1'b0, 32'h0009_1a34, 3'd0, 1'b0);  // Old tag is gone
    steps[14] = make_step(1'b0, 32'h0052_e200, 3'd0, 1'b0);  // Frozen read that misses too
    steps[15] = make_step(1'b0, 32'h0052_e23c, 3'd0, 1'b1);
    steps[16] = make_step(1'b1, 32'h0052_e200, 3'd1, 1'b0);  // Invalidate segment 2
    steps[17] = make_step(1'b0, 32'h0052_e23c, 3'd0, 1'b0);
    steps[18] = make_step(1'b0, 32'h0009_1d2c, 3'd0, 1'b1);  // Segment 5 untouched
    steps[19] = make_step(1'b0, 32'h0009_1d30, 3'd0, 1'b1);
    steps[20] = make_step(1'b1, 32'h0009_1d00, 3'd0, 1'b0);  // Invalidate segment 5
    steps[21] = make_step(1'b0, 32'h0052_e210, 3'd0, 1'b1);
    steps[22] = make_step(1'b0, 32'h0009_1d10, 3'd0, 1'b0);
    steps[23] = make_step(1'b0, 32'h0009_1d14, 3'd0, 1'b1);
    steps[24] = make_step(1'b0, 32'hffff_fffc, 3'd1, 1'b0);  // Top of the address space
    steps[25] = make_step(1'b0, 32'hffff_ff00, 3'd0, 1'b1);
    rd_req    = 1'b0;
    rd_adr    = '0;
    inv       = 1'b0;
    inv_adr   = '0;
    ref_vld   = '0;
    prev_miss = 1'b0;
    drain_due = 1'b0;
    do @(posedge rclk); while (rst);
    assert (!rsp.valid && !mem_req && !rd_busy) else begin
      $display("outputs are not idle after reset");
      abort_run();
    end
    for (int i = 0; i < n_steps; i++) begin
      st = steps[i];
      repeat (st.gap) begin
        @(posedge rclk);
        rd_req <= 1'b0;
        inv    <= 1'b0;
      end
      // Only one read may sit behind a miss, and an invalidate needs an empty pipe
      need_drain = drain_due || st.is_inv || (prev_miss && st.gap != 0);
      @(posedge rclk);
      while (rd_busy || (need_drain && exp_q.size() != 0)) begin
        rd_req <= 1'b0;
        inv    <= 1'b0;
        @(posedge rclk);
      end
      if (need_drain) begin
        prev_miss = 1'b0;
      end
      if (st.is_inv) begin
        rd_req  <= 1'b0;
        inv     <= 1'b1;
        inv_adr <= st.adr;
        ref_vld[st.adr[`MPMC_TAG_LSB-1:`MPMC_SEG_LSB]] = 1'b0;
        drain_due = 1'b0;
      end else begin
        predict_read(st.adr, hit);
        assert (hit == st.hit) else begin
          $display("table row %0d disagrees with the reference cache model", i);
          abort_run();
        end
        ex.dat     = mem_word(st.adr);
        ex.hit     = hit;
        ex.chk_lat = hit && !prev_miss;
        ex.edge_no = edge_no + 32'd1;  // Counter moves on at this very edge
        exp_q.push_back(ex);
        rd_req    <= 1'b1;
        rd_adr    <= st.adr;
        inv       <= 1'b0;
        drain_due = prev_miss;
        prev_miss = !hit;
      end
    end
    @(posedge rclk);
    rd_req <= 1'b0;
    inv    <= 1'b0;
    while (exp_q.size() != 0) begin
      @(posedge rclk);
    end
    repeat (8) @(posedge rclk);  // Room for a stray response to show up
    assert (fill_q.size() == 0 && mem_cnt == 0) begin
      $display("Finished with no errors");
      $finish;
    end else begin
      $display("segment fills did not match the expected misses");
      abort_run();
    end
  end

  // ====================================================================
  // Memory model and response checker
  // ====================================================================

  initial begin : mem_model
    logic [31:0] base;
    logic [31:0] exp_adr;
    int          lat;
    mem_ack   = 1'b0;
    mem_dat   = '0;
    mem_cnt   = 0;
    lcg_state = 32'h81d2_81bf;
    forever begin
      @(posedge rclk);
      if (mem_req) begin
        if (mem_cnt == 0) begin
          assert (fill_q.size() != 0) else begin
            $display("memory request issued with no miss outstanding");
            abort_run();
          end
          base = fill_q.pop_front();
        end
        exp_adr = base + (mem_cnt << `MPMC_LINE_LSB);  // Consecutive lines of the segment
        assert (mem_adr == exp_adr) else begin
          $display("MISMATCH t=%0t mem_adr got %h expected %h", $time, mem_adr, exp_adr);
          abort_run();
        end
        // The requester is held off for the whole fill
        assert (rd_busy) else begin
          $display("MISMATCH t=%0t rd_busy got %b expected 1", $time, rd_busy);
          abort_run();
        end
        mem_cnt   = (mem_cnt + 1) % `MPMC_SEG_LINES;
        lcg_state = lcg_next(lcg_state);
        lat       = 1 + lcg_state[17:16];  // 1 to 4 cycles
        repeat (lat - 1) @(posedge rclk);
        mem_ack <= 1'b1;
        mem_dat <= mem_line(mem_adr);
        @(posedge rclk);
        mem_ack <= 1'b0;
      end
    end
  end

  always @(negedge rclk) begin : rsp_check
    expect_t ex;
    if (rsp.valid) begin
      assert (exp_q.size() != 0) else begin
        $display("response at %0t with no read outstanding", $time);
        abort_run();
      end
      ex = exp_q.pop_front();
      assert (rsp.dat == ex.dat) else begin
        $display("MISMATCH t=%0t rsp.dat got %h expected %h", $time, rsp.dat, ex.dat);
        abort_run();
      end
      assert (rsp.hit == ex.hit) else begin
        $display("MISMATCH t=%0t rsp.hit got %b expected %b", $time, rsp.hit, ex.hit);
        abort_run();
      end
      if (ex.chk_lat) begin
        assert (edge_no - ex.edge_no == 32'd3) else begin
          $display("MISMATCH t=%0t rsp.valid latency got %0d expected 3",
                   $time, edge_no - ex.edge_no);
          abort_run();
        end
      end
    end
  end

  initial begin : watchdog
    repeat (wd_cycles) @(posedge rclk);
    $display("watchdog timeout: responses missing");
    abort_run();
  end

endmodule
